/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    alu_op_t         alu_op;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] store_data;
    reg_addr_t       rd;
    logic            wen;
    logic            mem_rd;
    logic            mem_wr;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    reg_addr_t       rd;
    logic            wen;
    logic            mem_rd;
    logic            mem_wr;
  } ex_mem_t;

  typedef struct packed {
    logic [xlen-1:0] result;
    reg_addr_t       rd;
    logic            wen;
  } mem_wb_t;

endpackage

`default_nettype wire

/* logic/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = cpu_pkg::if_id_t
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     en_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // All-zero payload has every enable cleared, so it is a bubble
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_o <= '0;
    end else if (flush_i) begin
      q_o <= '0;
    end else if (en_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     we_i,
  input  cpu_pkg::reg_addr_t       waddr_i,
  input  logic [cpu_pkg::xlen-1:0] wdata_i,
  input  cpu_pkg::reg_addr_t       raddr1_i,
  input  cpu_pkg::reg_addr_t       raddr2_i,
  output logic [cpu_pkg::xlen-1:0] rdata1_o,
  output logic [cpu_pkg::xlen-1:0] rdata2_o
);
  import cpu_pkg::*;

  logic [xlen-1:0] regs [32];

  // Same-cycle write is visible to the reader
  function automatic logic [xlen-1:0] read_port(input reg_addr_t raddr);
    if (we_i && waddr_i != '0 && waddr_i == raddr) begin
      return wdata_i;
    end
    return regs[raddr];
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = read_port(raddr1_i);
  assign rdata2_o = read_port(raddr2_i);

  a_x0_zero: assert property (@(posedge clk) disable iff (!rstn)
    (raddr1_i != '0 || rdata1_o == '0) && (raddr2_i != '0 || rdata2_o == '0));

endmodule

`default_nettype wire

/* logic/ifetch.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     hold_i,
  input  logic                     redirect_i,
  input  logic [cpu_pkg::xlen-1:0] target_i,
  output logic                     fetch_req_o,
  output logic [cpu_pkg::xlen-1:0] fetch_addr_o,
  input  logic                     fetch_ack_i,
  input  logic [cpu_pkg::xlen-1:0] fetch_rdata_i,
  output logic                     inst_valid_o,
  output logic [cpu_pkg::xlen-1:0] inst_o,
  output logic [cpu_pkg::xlen-1:0] pc_o
);
  import cpu_pkg::*;

  logic [xlen-1:0] pc_q;
  logic            run_q;
  logic            buf_valid_q;
  logic [xlen-1:0] buf_inst_q;
  logic [xlen-1:0] buf_pc_q;

  // A redirect is only accepted when an instruction is being consumed,
  // so the address never moves under an outstanding request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc_q        <= reset_pc;
      run_q       <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (redirect_i) begin
        pc_q <= target_i;
      end else if (fetch_ack_i) begin
        pc_q <= pc_q + xlen'(4);
      end
      if (fetch_ack_i && hold_i) begin
        buf_valid_q <= 1'b1;
      end else if (!hold_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ack_i && hold_i) begin
      buf_inst_q <= fetch_rdata_i;
      buf_pc_q   <= pc_q;
    end
  end

  assign fetch_req_o  = run_q && !buf_valid_q;
  assign fetch_addr_o = pc_q;
  assign inst_valid_o = buf_valid_q || fetch_ack_i;
  assign inst_o       = buf_valid_q ? buf_inst_q : fetch_rdata_i;
  assign pc_o         = buf_valid_q ? buf_pc_q : pc_q;

endmodule

`default_nettype wire

/* logic/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  cpu_pkg::if_id_t          if_id_i,
  input  logic [cpu_pkg::xlen-1:0] rdata1_i,
  input  logic [cpu_pkg::xlen-1:0] rdata2_i,
  input  cpu_pkg::ex_mem_t         ex_fwd_i,
  input  cpu_pkg::mem_wb_t         wb_fwd_i,
  output cpu_pkg::reg_addr_t       raddr1_o,
  output cpu_pkg::reg_addr_t       raddr2_o,
  output cpu_pkg::id_ex_t          id_ex_o,
  output logic                     load_use_o,
  output logic                     redirect_o,
  output logic [cpu_pkg::xlen-1:0] target_o
);
  import cpu_pkg::*;

  logic [xlen-1:0] inst;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  reg_addr_t       rd;
  reg_addr_t       rs1;
  reg_addr_t       rs2;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;

  // Nearest producer wins; the regfile covers the writeback stage
  function automatic logic [xlen-1:0] forward(input reg_addr_t raddr,
                                              input logic [xlen-1:0] rdata);
    if (raddr != '0 && ex_fwd_i.wen && ex_fwd_i.rd == raddr) begin
      return ex_fwd_i.result;
    end
    if (raddr != '0 && wb_fwd_i.wen && wb_fwd_i.rd == raddr) begin
      return wb_fwd_i.result;
    end
    return rdata;
  endfunction

  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  return sub ? alu_sub : alu_add;
      3'b010:  return alu_slt;
      3'b100:  return alu_xor;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign inst   = if_id_i.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign raddr1_o = rs1;
  assign raddr2_o = rs2;
  assign rs1_val  = forward(rs1, rdata1_i);
  assign rs2_val  = forward(rs2, rdata2_i);

  // Load result is not ready until the memory stage
  assign load_use_o = ex_fwd_i.mem_rd && ex_fwd_i.wen && ex_fwd_i.rd != '0 &&
                      (ex_fwd_i.rd == rs1 || ex_fwd_i.rd == rs2);

  always_comb begin
    id_ex_o            = '0;
    id_ex_o.pc         = if_id_i.pc;
    id_ex_o.rd         = rd;
    id_ex_o.opa        = rs1_val;
    id_ex_o.store_data = rs2_val;
    redirect_o         = 1'b0;
    target_o           = if_id_i.pc + imm_b;
    case (opcode)
      op_imm: begin
        id_ex_o.alu_op = arith_op(funct3, 1'b0);
        id_ex_o.opb    = imm_i;
        id_ex_o.wen    = 1'b1;
      end
      op_reg: begin
        id_ex_o.alu_op = arith_op(funct3, inst[30]);
        id_ex_o.opb    = rs2_val;
        id_ex_o.wen    = 1'b1;
      end
      op_lui: begin
        id_ex_o.alu_op = alu_pass_b;
        id_ex_o.opb    = imm_u;
        id_ex_o.wen    = 1'b1;
      end
      op_load: begin
        id_ex_o.opb    = imm_i;
        id_ex_o.wen    = 1'b1;
        id_ex_o.mem_rd = 1'b1;
      end
      op_store: begin
        id_ex_o.opb    = imm_s;
        id_ex_o.mem_wr = 1'b1;
      end
      op_branch: begin
        redirect_o = (funct3 == 3'b000) ? (rs1_val == rs2_val) :
                     (funct3 == 3'b001) && (rs1_val != rs2_val);
      end
      op_jal: begin
        // Link value goes down the pipe as operand B
        id_ex_o.alu_op = alu_pass_b;
        id_ex_o.opb    = if_id_i.pc + xlen'(4);
        id_ex_o.wen    = 1'b1;
        redirect_o     = 1'b1;
        target_o       = if_id_i.pc + imm_j;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  cpu_pkg::id_ex_t  id_ex_i,
  output cpu_pkg::ex_mem_t ex_mem_o
);
  import cpu_pkg::*;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] result;

  assign a = id_ex_i.opa;
  assign b = id_ex_i.opb;

  always_comb begin
    case (id_ex_i.alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // For loads and stores the result is the address
  assign ex_mem_o.result     = result;
  assign ex_mem_o.store_data = id_ex_i.store_data;
  assign ex_mem_o.rd         = id_ex_i.rd;
  assign ex_mem_o.wen        = id_ex_i.wen;
  assign ex_mem_o.mem_rd     = id_ex_i.mem_rd;
  assign ex_mem_o.mem_wr     = id_ex_i.mem_wr;

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  output logic                     fetch_req_o,
  output logic [cpu_pkg::xlen-1:0] fetch_addr_o,
  input  logic                     fetch_ack_i,
  input  logic [cpu_pkg::xlen-1:0] fetch_rdata_i,
  output logic                     data_req_o,
  output logic                     data_we_o,
  output logic [cpu_pkg::xlen-1:0] data_addr_o,
  output logic [cpu_pkg::xlen-1:0] data_wdata_o,
  input  logic                     data_ack_i,
  input  logic [cpu_pkg::xlen-1:0] data_rdata_i
);
  import cpu_pkg::*;

  if_id_t          if_id_d;
  if_id_t          if_id_q;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;
  ex_mem_t         ex_mem_d;
  ex_mem_t         ex_mem_q;
  mem_wb_t         mem_wb_d;
  mem_wb_t         mem_wb_q;

  logic            inst_valid;
  logic [xlen-1:0] fetch_inst;
  logic [xlen-1:0] fetch_pc;
  reg_addr_t       raddr1;
  reg_addr_t       raddr2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic            load_use;
  logic            redirect;
  logic [xlen-1:0] target;
  logic            data_wait;
  logic            id_adv;

  // Data wait freezes everything; decode also needs the next instruction
  assign data_wait = data_req_o && !data_ack_i;
  assign id_adv    = !data_wait && !load_use && inst_valid;

  ifetch #(
    .reset_pc(reset_pc)
  ) u_ifetch (
    .clk          (clk),
    .rstn         (rstn),
    .hold_i       (!id_adv),
    .redirect_i   (redirect && id_adv),
    .target_i     (target),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o),
    .fetch_ack_i  (fetch_ack_i),
    .fetch_rdata_i(fetch_rdata_i),
    .inst_valid_o (inst_valid),
    .inst_o       (fetch_inst),
    .pc_o         (fetch_pc)
  );

  assign if_id_d = '{pc: fetch_pc, inst: fetch_inst};

  // Taken branch drops the instruction fetched behind it
  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (id_adv),
    .flush_i(id_adv && redirect),
    .d_i    (if_id_d),
    .q_o    (if_id_q)
  );

  regfile u_regfile (
    .clk     (clk),
    .rstn    (rstn),
    .we_i    (mem_wb_q.wen),
    .waddr_i (mem_wb_q.rd),
    .wdata_i (mem_wb_q.result),
    .raddr1_i(raddr1),
    .raddr2_i(raddr2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2)
  );

  decode u_decode (
    .if_id_i   (if_id_q),
    .rdata1_i  (rdata1),
    .rdata2_i  (rdata2),
    .ex_fwd_i  (ex_mem_d),
    .wb_fwd_i  (mem_wb_d),
    .raddr1_o  (raddr1),
    .raddr2_o  (raddr2),
    .id_ex_o   (id_ex_d),
    .load_use_o(load_use),
    .redirect_o(redirect),
    .target_o  (target)
  );

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (id_adv),
    .flush_i(!data_wait && !id_adv),
    .d_i    (id_ex_d),
    .q_o    (id_ex_q)
  );

  execute u_execute (
    .id_ex_i (id_ex_q),
    .ex_mem_o(ex_mem_d)
  );

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (!data_wait),
    .flush_i(1'b0),
    .d_i    (ex_mem_d),
    .q_o    (ex_mem_q)
  );

  assign data_req_o   = ex_mem_q.mem_rd || ex_mem_q.mem_wr;
  assign data_we_o    = ex_mem_q.mem_wr;
  assign data_addr_o  = ex_mem_q.result;
  assign data_wdata_o = ex_mem_q.store_data;

  // Load data is only valid in the acknowledge cycle
  assign mem_wb_d.result = ex_mem_q.mem_rd ? data_rdata_i : ex_mem_q.result;
  assign mem_wb_d.rd     = ex_mem_q.rd;
  assign mem_wb_d.wen    = ex_mem_q.wen;

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (!data_wait),
    .flush_i(1'b0),
    .d_i    (mem_wb_d),
    .q_o    (mem_wb_q)
  );

  a_data_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    data_req_o && !data_ack_i |=> data_req_o && $stable(data_we_o) &&
      $stable(data_addr_o) && $stable(data_wdata_o));

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     fetch_req_i,
  input  logic [cpu_pkg::xlen-1:0] fetch_addr_i,
  output logic                     fetch_ack_o,
  output logic [cpu_pkg::xlen-1:0] fetch_rdata_o,
  input  logic                     data_req_i,
  input  logic                     data_we_i,
  input  logic [cpu_pkg::xlen-1:0] data_addr_i,
  input  logic [cpu_pkg::xlen-1:0] data_wdata_i,
  output logic                     data_ack_o,
  output logic [cpu_pkg::xlen-1:0] data_rdata_o,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [cpu_pkg::xlen-1:0] mem_addr_o,
  output logic [cpu_pkg::xlen-1:0] mem_wdata_o,
  input  logic [cpu_pkg::xlen-1:0] mem_rdata_i,
  input  logic                     mem_ack_i
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {gnt_idle, gnt_fetch, gnt_data} gnt_t;

  gnt_t state_q;
  gnt_t sel;
  logic gnt_f;
  logic gnt_d;

  // New grant picked the same cycle the port goes idle
  always_comb begin
    sel = state_q;
    if (state_q == gnt_idle) begin
      if (data_req_i) begin
        sel = gnt_data;
      end else if (fetch_req_i) begin
        sel = gnt_fetch;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= gnt_idle;
    end else if (mem_ack_i) begin
      state_q <= gnt_idle;
    end else begin
      state_q <= sel;
    end
  end

  assign gnt_f = (sel == gnt_fetch);
  assign gnt_d = (sel == gnt_data);

  assign mem_req_o   = gnt_f || gnt_d;
  assign mem_we_o    = gnt_d && data_we_i;
  assign mem_addr_o  = gnt_d ? data_addr_i : fetch_addr_i;
  assign mem_wdata_o = gnt_d ? data_wdata_i : '0;

  assign fetch_ack_o   = mem_ack_i && gnt_f;
  assign data_ack_o    = mem_ack_i && gnt_d;
  assign fetch_rdata_o = mem_rdata_i;
  assign data_rdata_o  = mem_rdata_i;

  // Granted side keeps requesting until its acknowledge
  a_gnt_req_held: assert property (@(posedge clk) disable iff (!rstn)
    (state_q != gnt_fetch || fetch_req_i) && (state_q != gnt_data || data_req_i));

  a_no_idle_ack: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack_i |-> state_q != gnt_idle);

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [cpu_pkg::xlen-1:0] mem_addr_o,
  output logic [cpu_pkg::xlen-1:0] mem_wdata_o,
  input  logic [cpu_pkg::xlen-1:0] mem_rdata_i,
  input  logic                     mem_ack_i
);
  import cpu_pkg::*;

  logic            fetch_req;
  logic [xlen-1:0] fetch_addr;
  logic            fetch_ack;
  logic [xlen-1:0] fetch_rdata;
  logic            data_req;
  logic            data_we;
  logic [xlen-1:0] data_addr;
  logic [xlen-1:0] data_wdata;
  logic            data_ack;
  logic [xlen-1:0] data_rdata;

  cpu_core #(
    .reset_pc(reset_pc)
  ) u_core (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_req_o  (fetch_req),
    .fetch_addr_o (fetch_addr),
    .fetch_ack_i  (fetch_ack),
    .fetch_rdata_i(fetch_rdata),
    .data_req_o   (data_req),
    .data_we_o    (data_we),
    .data_addr_o  (data_addr),
    .data_wdata_o (data_wdata),
    .data_ack_i   (data_ack),
    .data_rdata_i (data_rdata)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .fetch_ack_o  (fetch_ack),
    .fetch_rdata_o(fetch_rdata),
    .data_req_i   (data_req),
    .data_we_i    (data_we),
    .data_addr_i  (data_addr),
    .data_wdata_i (data_wdata),
    .data_ack_o   (data_ack),
    .data_rdata_o (data_rdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_ack_i    (mem_ack_i)
  );

endmodule

`default_nettype wire

/* testbench/tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     mem_req_i,
  input  logic                     mem_we_i,
  input  logic [cpu_pkg::xlen-1:0] mem_addr_i,
  input  logic [cpu_pkg::xlen-1:0] mem_wdata_i,
  output logic [cpu_pkg::xlen-1:0] mem_rdata_o,
  output logic                     mem_ack_o
);
  import cpu_pkg::*;

  logic [xlen-1:0] mem [256];
  integer          seed;
  int              cnt;
  bit              busy;

  function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de0000 ^ (i << 2);
    end
    // ALU chain with forwarding
    mem[0]  = alu_imm(3'b000, 5'd1, 5'd0, 12'h005);
    mem[1]  = alu_imm(3'b000, 5'd2, 5'd1, 12'h007);
    mem[2]  = alu_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    mem[3]  = alu_reg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
    mem[4]  = alu_reg(7'h00, 3'b111, 5'd5, 5'd3, 5'd1);
    mem[5]  = alu_reg(7'h00, 3'b110, 5'd6, 5'd3, 5'd2);
    mem[6]  = alu_reg(7'h00, 3'b100, 5'd7, 5'd6, 5'd1);
    mem[7]  = alu_reg(7'h00, 3'b010, 5'd8, 5'd1, 5'd7);
    mem[8]  = alu_imm(3'b000, 5'd9, 5'd0, 12'hffd);
    mem[9]  = alu_reg(7'h00, 3'b010, 5'd10, 5'd1, 5'd9);
    mem[10] = upper_imm(5'd11, 20'h12345);
    mem[11] = alu_reg(7'h00, 3'b000, 5'd12, 5'd11, 5'd6);
    mem[12] = store_word(5'd3, 5'd0, 12'h200);
    mem[13] = store_word(5'd4, 5'd0, 12'h204);
    mem[14] = store_word(5'd5, 5'd0, 12'h208);
    mem[15] = store_word(5'd6, 5'd0, 12'h20c);
    mem[16] = store_word(5'd7, 5'd0, 12'h210);
    mem[17] = store_word(5'd8, 5'd0, 12'h214);
    mem[18] = store_word(5'd10, 5'd0, 12'h218);
    mem[19] = store_word(5'd12, 5'd0, 12'h21c);
    // Load-use pairs
    mem[20] = load_word(5'd13, 5'd0, 12'h300);
    mem[21] = alu_reg(7'h00, 3'b000, 5'd14, 5'd13, 5'd1);
    mem[22] = store_word(5'd14, 5'd0, 12'h220);
    mem[23] = load_word(5'd15, 5'd0, 12'h200);
    mem[24] = alu_imm(3'b000, 5'd16, 5'd15, 12'h001);
    mem[25] = store_word(5'd16, 5'd0, 12'h224);
    // Branch tests with markers at 0x2f0 and up that must never be written
    mem[26] = branch(3'b000, 5'd1, 5'd1, 13'd12);
    mem[27] = store_word(5'd1, 5'd0, 12'h2f0);
    mem[28] = store_word(5'd1, 5'd0, 12'h2f4);
    mem[29] = branch(3'b001, 5'd1, 5'd1, 13'd8);
    mem[30] = store_word(5'd2, 5'd0, 12'h228);
    mem[31] = branch(3'b001, 5'd1, 5'd2, 13'd8);
    mem[32] = store_word(5'd1, 5'd0, 12'h2f8);
    mem[33] = branch(3'b000, 5'd1, 5'd2, 13'd8);
    mem[34] = store_word(5'd3, 5'd0, 12'h22c);
    mem[35] = jump_link(5'd17, 21'd12);
    mem[36] = store_word(5'd1, 5'd0, 12'h2fc);
    mem[37] = store_word(5'd1, 5'd0, 12'h2fc);
    mem[38] = store_word(5'd17, 5'd0, 12'h230);
    // Park in a self loop
    mem[39] = jump_link(5'd0, 21'd0);
    mem[192] = 32'h00000100;
  end

  // One access at a time with a random 1 to 4 cycle latency
  initial begin
    seed        = 20;
    busy        = 1'b0;
    cnt         = 0;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_ack_o = 1'b0;
      if (!rstn) begin
        busy = 1'b0;
      end else if (busy) begin
        cnt = cnt - 1;
        if (cnt == 0) begin
          busy      = 1'b0;
          mem_ack_o = 1'b1;
          if (mem_we_i) begin
            mem[mem_addr_i[9:2]] = mem_wdata_i;
          end else begin
            mem_rdata_o = mem[mem_addr_i[9:2]];
          end
        end
      end else if (mem_req_i) begin
        busy = 1'b1;
        cnt  = 1 + ($unsigned($random(seed)) % 4);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam logic [xlen-1:0] reset_pc = 32'h0;
  localparam int n_stores = 13;

  logic            clk;
  logic            rstn;
  logic            mem_req_o;
  logic            mem_we_o;
  logic [xlen-1:0] mem_addr_o;
  logic [xlen-1:0] mem_wdata_o;
  logic [xlen-1:0] mem_rdata_i;
  logic            mem_ack_i;

  logic [xlen-1:0] exp_addr [n_stores];
  logic [xlen-1:0] exp_data [n_stores];
  int              store_idx;
  int              err_count;
  int              tests_passed;
  int              tests_failed;

  cpu_top #(.reset_pc(reset_pc)) dut (
    .clk        (clk),
    .rstn       (rstn),
    .mem_req_o  (mem_req_o),
    .mem_we_o   (mem_we_o),
    .mem_addr_o (mem_addr_o),
    .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i),
    .mem_ack_i  (mem_ack_i)
  );

  tb_memory u_memory (
    .clk        (clk),
    .rstn       (rstn),
    .mem_req_i  (mem_req_o),
    .mem_we_i   (mem_we_o),
    .mem_addr_i (mem_addr_o),
    .mem_wdata_i(mem_wdata_o),
    .mem_rdata_o(mem_rdata_i),
    .mem_ack_o  (mem_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hand-derived store trace of the program
  initial begin
    exp_addr[0]  = 32'h200;
    exp_data[0]  = 32'h11;
    exp_addr[1]  = 32'h204;
    exp_data[1]  = 32'h0c;
    exp_addr[2]  = 32'h208;
    exp_data[2]  = 32'h01;
    exp_addr[3]  = 32'h20c;
    exp_data[3]  = 32'h1d;
    exp_addr[4]  = 32'h210;
    exp_data[4]  = 32'h18;
    exp_addr[5]  = 32'h214;
    exp_data[5]  = 32'h01;
    exp_addr[6]  = 32'h218;
    exp_data[6]  = 32'h00;
    exp_addr[7]  = 32'h21c;
    exp_data[7]  = 32'h1234501d;
    exp_addr[8]  = 32'h220;
    exp_data[8]  = 32'h105;
    exp_addr[9]  = 32'h224;
    exp_data[9]  = 32'h12;
    exp_addr[10] = 32'h228;
    exp_data[10] = 32'h0c;
    exp_addr[11] = 32'h22c;
    exp_data[11] = 32'h11;
    exp_addr[12] = 32'h230;
    exp_data[12] = 32'h90;
  end

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      store_idx <= 0;
    end else if (mem_ack_i && mem_we_o) begin
      store_idx <= store_idx + 1;
    end
  end

  a_reset_idle: assert property (@(posedge clk) !rstn |-> !mem_req_o && !mem_we_o)
    else begin
      $display("Memory request raised during reset");
      err_count++;
    end

  a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) &&
      $stable(mem_we_o) && $stable(mem_wdata_o))
    else begin
      $display("Memory request changed before its acknowledge");
      err_count++;
    end

  a_no_marker: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack_i && mem_we_o |-> !(mem_addr_o >= 32'h2f0 && mem_addr_o < 32'h300))
    else begin
      $display("Store behind a taken branch reached memory");
      err_count++;
    end

  a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack_i && mem_we_o |-> store_idx < n_stores)
    else begin
      $display("Store beyond the expected sequence");
      err_count++;
    end

  a_store_addr: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack_i && mem_we_o && store_idx < n_stores |-> mem_addr_o == exp_addr[store_idx])
    else begin
      $display("Mismatch mem_addr_o: expected %h, got %h",
               exp_addr[$sampled(store_idx)], $sampled(mem_addr_o));
      err_count++;
    end

  a_store_data: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack_i && mem_we_o && store_idx < n_stores |-> mem_wdata_o == exp_data[store_idx])
    else begin
      $display("Mismatch mem_wdata_o: expected %h, got %h",
               exp_data[$sampled(store_idx)], $sampled(mem_wdata_o));
      err_count++;
    end

  task automatic report_test(input string name, input int errs_at_start, input bit timed_out);
    if (timed_out || err_count != errs_at_start) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      tests_passed++;
      $display("test %s: ok", name);
    end
  endtask

  task automatic wait_for_stores(input int count, input int limit, output bit timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while (store_idx < count && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (store_idx < count) begin
      timed_out = 1'b1;
      $display("Timed out waiting for store %0d, saw only %0d", count, store_idx);
    end
  endtask

  initial begin
    bit timed_out;
    int cycles;
    int mark;
    rstn         = 1'b0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    mark         = err_count;
    repeat (16) @(posedge clk);
    #1 rstn = 1'b1;

    timed_out = 1'b0;
    cycles    = 0;
    while (!mem_req_o && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_req_o) begin
      timed_out = 1'b1;
      $display("Timed out waiting for the first fetch after reset");
    end else begin
      assert (mem_addr_o == reset_pc && !mem_we_o)
        else begin
          $display("Mismatch mem_addr_o: expected %h, got %h", reset_pc, mem_addr_o);
          err_count++;
        end
    end
    report_test("reset", mark, timed_out);

    mark = err_count;
    wait_for_stores(8, 2000, timed_out);
    report_test("alu_forwarding", mark, timed_out);

    mark = err_count;
    wait_for_stores(10, 1000, timed_out);
    report_test("load_use", mark, timed_out);

    mark = err_count;
    wait_for_stores(13, 1000, timed_out);
    report_test("branch_jal", mark, timed_out);

    // Let the self loop run to expose any late or extra store
    mark = err_count;
    repeat (100) @(negedge clk);
    assert (store_idx == n_stores)
      else begin
        $display("Store sequence incomplete or too long: %0d of %0d", store_idx, n_stores);
        err_count++;
      end
    report_test("latency_sequence", mark, 1'b0);

    $display("tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/cpu_pkg.sv
logic/pipe_reg.sv
logic/regfile.sv
logic/ifetch.sv
logic/decode.sv
logic/execute.sv
logic/cpu_core.sv
logic/mem_arbiter.sv
logic/cpu_top.sv
testbench/tb_memory.sv
testbench/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu \
  -f compile.f --Mdir obj_dir -o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
grep -q ">>> PASS" sim.log
